// File: hw/resonant_pkg.sv
package resonant_pkg;

	// ========================================
	// Loop dimensions
	// ========================================
	localparam int unsigned HARMONICS_NUM = 8;
	localparam int unsigned IN_SERIES_NUM = 3;
	localparam int unsigned HARM_CNT_W = $clog2(HARMONICS_NUM);
	localparam int unsigned SERIES_CNT_W = $clog2(IN_SERIES_NUM);

	// ========================================
	// Memory map
	// ========================================
	localparam int unsigned ADDR_W = 9;
	localparam int unsigned RAM_DEPTH = 2**ADDR_W;
	localparam int unsigned BANK_W = ADDR_W - SERIES_CNT_W;    // In-bank offset bits
	localparam int unsigned COEF_COMMON_BASE = HARMONICS_NUM;  // Sample of series 0
	localparam int unsigned STATE_SUM_OFFSET = HARMONICS_NUM;  // Sum slot after the states

	// ========================================
	// Arithmetic
	// ========================================
	localparam int unsigned SAMPLE_W = 18;
	localparam int unsigned Q_SHIFT = 16;                      // 1.0 is 65536
	localparam int unsigned PROD_W = 2*SAMPLE_W + 1;           // Sum of two products

	typedef struct packed {
		logic signed [SAMPLE_W-1:0] x1;
		logic signed [SAMPLE_W-1:0] x2;
	} state_word_t;

	typedef struct packed {
		logic signed [SAMPLE_W-1:0] co;                        // Also the series sample
		logic signed [SAMPLE_W-1:0] si;
	} coef_word_t;

	typedef struct packed {
		logic we;
		logic [ADDR_W-1:0] addr;
		state_word_t word;
	} mem_wr_t;

	typedef struct packed {
		logic we;
		logic [ADDR_W-1:0] addr;
		coef_word_t word;
	} coef_wr_t;

	typedef enum logic [1:0] {
		ACC_SAMPLE,
		ACC_SUM,
		ACC_HARM
	} access_t;

	typedef enum logic [3:0] {
		IDLE,
		RD_COMMON,
		WAIT_COMMON,
		RD_HARM,
		WAIT_HARM,
		CALC,
		WR_HARM,
		WR_SUM,
		NEXT_SERIES
	} seq_state_t;

endpackage

// File: hw/dp_ram.sv
module dp_ram
	import resonant_pkg::*;
#(
	parameter type word_t = state_word_t
) (
	input  logic              clk_i,
	input  logic              wr_en_i,
	input  logic [ADDR_W-1:0] wr_addr_i,
	input  word_t             wr_data_i,
	input  logic [ADDR_W-1:0] rd_addr_i,
	output word_t             rd_data_o
);

	word_t mem [RAM_DEPTH] = '{default: '0};

	always_ff @(posedge clk_i) begin
		if (wr_en_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
		rd_data_o <= mem[rd_addr_i];    // Registered read, old data on collision
	end

endmodule

// File: hw/addr_gen.sv
module addr_gen
	import resonant_pkg::*;
(
	input  logic                    clk_i,
	input  logic                    harmonics_rst,
	input  access_t                 acc_kind_i,
	input  logic [HARM_CNT_W-1:0]   harm_cnt_i,
	input  logic [SERIES_CNT_W-1:0] series_cnt_i,
	output logic [ADDR_W-1:0]       state_rd_addr_o,
	output logic [ADDR_W-1:0]       coef_rd_addr_o
);

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			state_rd_addr_o <= '0;
			coef_rd_addr_o <= '0;
		end else begin
			case (acc_kind_i)
				ACC_HARM: begin
					state_rd_addr_o <= {series_cnt_i, BANK_W'(harm_cnt_i)};
					coef_rd_addr_o <= ADDR_W'(harm_cnt_i);
				end
				ACC_SAMPLE: begin
					state_rd_addr_o <= {series_cnt_i, BANK_W'(STATE_SUM_OFFSET)};
					coef_rd_addr_o <= ADDR_W'(COEF_COMMON_BASE + series_cnt_i);
				end
				default: begin
					state_rd_addr_o <= {series_cnt_i, BANK_W'(STATE_SUM_OFFSET)};
					coef_rd_addr_o <= ADDR_W'(harm_cnt_i);
				end
			endcase
		end
	end

endmodule

// File: hw/loop_counters.sv
module loop_counters
	import resonant_pkg::*;
(
	input  logic                    clk_i,
	input  logic                    harmonics_rst,
	input  logic                    harm_inc_i,
	input  logic                    harm_clr_i,
	input  logic                    series_inc_i,
	input  logic                    series_clr_i,
	output logic [HARM_CNT_W-1:0]   harm_cnt_o,
	output logic [SERIES_CNT_W-1:0] series_cnt_o,
	output logic                    harm_end_o,
	output logic                    series_end_o
);

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			harm_cnt_o <= '0;
			series_cnt_o <= '0;
			harm_end_o <= 1'b0;
			series_end_o <= 1'b0;
		end else begin
			if (harm_clr_i) begin
				harm_cnt_o <= '0;
			end else if (harm_inc_i) begin
				harm_cnt_o <= harm_cnt_o + 1'b1;
			end
			if (series_clr_i) begin
				series_cnt_o <= '0;
			end else if (series_inc_i) begin
				series_cnt_o <= series_cnt_o + 1'b1;
			end
			// Flags lag the counts by one cycle
			harm_end_o <= (harm_cnt_o == HARM_CNT_W'(HARMONICS_NUM - 1));
			series_end_o <= (series_cnt_o == SERIES_CNT_W'(IN_SERIES_NUM - 1));
		end
	end

endmodule

// File: hw/resonant_sequencer.sv
module resonant_sequencer
	import resonant_pkg::*;
(
	input  logic    clk_i,
	input  logic    harmonics_rst,
	input  logic    start_i,
	input  logic    harm_end_i,
	input  logic    series_end_i,
	output access_t acc_kind_o,
	output logic    harm_inc_o,
	output logic    harm_clr_o,
	output logic    series_inc_o,
	output logic    series_clr_o,
	output logic    load_sample_o,
	output logic    load_sum_o,
	output logic    calc_o,
	output logic    wr_harm_o,
	output logic    wr_sum_o,
	output logic    busy_o
);

	seq_state_t state_q;
	seq_state_t state_d;
	logic sum_phase_q;    // Second pass of the common reads

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:        if (start_i) state_d = RD_COMMON;
			RD_COMMON:   state_d = WAIT_COMMON;
			WAIT_COMMON: state_d = sum_phase_q ? RD_HARM : RD_COMMON;
			RD_HARM:     state_d = WAIT_HARM;
			WAIT_HARM:   state_d = CALC;
			CALC:        state_d = WR_HARM;
			WR_HARM:     state_d = harm_end_i ? WR_SUM : RD_HARM;
			WR_SUM:      state_d = NEXT_SERIES;
			NEXT_SERIES: state_d = series_end_i ? IDLE : RD_COMMON;
			default:     state_d = IDLE;
		endcase
	end

	// Kind of the read issued in this cycle
	always_comb begin
		case (state_q)
			RD_COMMON, WAIT_COMMON: acc_kind_o = sum_phase_q ? ACC_SUM : ACC_SAMPLE;
			RD_HARM, WAIT_HARM, CALC: acc_kind_o = ACC_HARM;
			default: acc_kind_o = ACC_SUM;    // Sum address for the sum write
		endcase
	end

	assign harm_inc_o = (state_q == WR_HARM) && !harm_end_i;
	assign harm_clr_o = ((state_q == WR_HARM) && harm_end_i)
		|| ((state_q == NEXT_SERIES) && series_end_i);
	assign series_inc_o = (state_q == NEXT_SERIES) && !series_end_i;
	assign series_clr_o = (state_q == NEXT_SERIES) && series_end_i;
	assign busy_o = (state_q != IDLE);

	// ========================================
	// Datapath strobes, aligned with read data
	// ========================================
	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			state_q <= IDLE;
			sum_phase_q <= 1'b0;
			load_sample_o <= 1'b0;
			load_sum_o <= 1'b0;
			calc_o <= 1'b0;
			wr_harm_o <= 1'b0;
			wr_sum_o <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == WAIT_COMMON) begin
				sum_phase_q <= !sum_phase_q;
			end
			load_sample_o <= (state_q == WAIT_COMMON) && !sum_phase_q;
			load_sum_o <= (state_q == WAIT_COMMON) && sum_phase_q;
			calc_o <= (state_q == WAIT_HARM);
			wr_harm_o <= (state_q == WAIT_HARM);
			wr_sum_o <= (state_q == WR_HARM) && harm_end_i;    // Write lands in NEXT_SERIES
		end
	end

endmodule

// File: hw/resonator_datapath.sv
module resonator_datapath
	import resonant_pkg::*;
(
	input  logic              clk_i,
	input  logic              harmonics_rst,
	input  logic              load_sample_i,
	input  logic              load_sum_i,
	input  logic              calc_i,
	input  logic              wr_harm_i,
	input  logic              wr_sum_i,
	input  state_word_t       state_rd_i,
	input  coef_word_t        coef_rd_i,
	input  logic [ADDR_W-1:0] state_rd_addr_i,
	output mem_wr_t           state_wr_o
);

	logic signed [SAMPLE_W-1:0] sample_q;
	logic signed [SAMPLE_W-1:0] err_q;
	logic signed [SAMPLE_W-1:0] sum_q;
	logic signed [PROD_W-1:0] rot1_full;
	logic signed [PROD_W-1:0] rot2_full;
	logic signed [PROD_W-1:0] rot1_sh;
	logic signed [PROD_W-1:0] rot2_sh;
	logic signed [SAMPLE_W-1:0] x1_new;
	logic signed [SAMPLE_W-1:0] x2_new;
	state_word_t wr_word;
	logic wr_we_q;
	logic [ADDR_W-1:0] wr_addr_q;
	state_word_t wr_word_q;

	// ========================================
	// Rotation
	// ========================================
	always_comb begin
		rot1_full = PROD_W'($signed(coef_rd_i.co)) * PROD_W'($signed(state_rd_i.x1))
			- PROD_W'($signed(coef_rd_i.si)) * PROD_W'($signed(state_rd_i.x2));
		rot2_full = PROD_W'($signed(coef_rd_i.si)) * PROD_W'($signed(state_rd_i.x1))
			+ PROD_W'($signed(coef_rd_i.co)) * PROD_W'($signed(state_rd_i.x2));
		rot1_sh = rot1_full >>> Q_SHIFT;
		rot2_sh = rot2_full >>> Q_SHIFT;
		x1_new = rot1_sh[SAMPLE_W-1:0] + err_q;    // Error drives the first state
		x2_new = rot2_sh[SAMPLE_W-1:0];
		wr_word.x1 = wr_sum_i ? sum_q : x1_new;
		wr_word.x2 = wr_sum_i ? '0 : x2_new;
	end

	always_ff @(posedge clk_i) begin
		if (load_sample_i) begin
			sample_q <= coef_rd_i.co;
		end
		if (load_sum_i) begin
			err_q <= sample_q - state_rd_i.x1;    // Previous sum of this series
			sum_q <= '0;
		end else if (calc_i) begin
			sum_q <= sum_q + x1_new;
		end
		if (wr_harm_i || wr_sum_i) begin
			wr_addr_q <= state_rd_addr_i;
			wr_word_q <= wr_word;
		end
	end

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			wr_we_q <= 1'b0;
		end else begin
			wr_we_q <= wr_harm_i || wr_sum_i;
		end
	end

	assign state_wr_o = '{we: wr_we_q, addr: wr_addr_q, word: wr_word_q};

endmodule

// File: hw/resonant_top.sv
module resonant_top
	import resonant_pkg::*;
(
	input  logic     clk_i,
	input  logic     harmonics_rst,
	input  logic     start_i,
	input  coef_wr_t coef_wr_i,
	output logic     busy_o,
	output mem_wr_t  state_wr_o
);

	access_t acc_kind;
	logic harm_inc;
	logic harm_clr;
	logic series_inc;
	logic series_clr;
	logic harm_end;
	logic series_end;
	logic load_sample;
	logic load_sum;
	logic calc;
	logic wr_harm;
	logic wr_sum;
	logic [HARM_CNT_W-1:0] harm_cnt;
	logic [SERIES_CNT_W-1:0] series_cnt;
	logic [ADDR_W-1:0] state_rd_addr;
	logic [ADDR_W-1:0] coef_rd_addr;
	state_word_t state_rd;
	coef_word_t coef_rd;

	resonant_sequencer u_seq (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst), .start_i(start_i),
		.harm_end_i(harm_end), .series_end_i(series_end), .acc_kind_o(acc_kind),
		.harm_inc_o(harm_inc), .harm_clr_o(harm_clr),
		.series_inc_o(series_inc), .series_clr_o(series_clr),
		.load_sample_o(load_sample), .load_sum_o(load_sum), .calc_o(calc),
		.wr_harm_o(wr_harm), .wr_sum_o(wr_sum), .busy_o(busy_o)
	);

	loop_counters u_cnt (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst),
		.harm_inc_i(harm_inc), .harm_clr_i(harm_clr),
		.series_inc_i(series_inc), .series_clr_i(series_clr),
		.harm_cnt_o(harm_cnt), .series_cnt_o(series_cnt),
		.harm_end_o(harm_end), .series_end_o(series_end)
	);

	addr_gen u_addr (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst), .acc_kind_i(acc_kind),
		.harm_cnt_i(harm_cnt), .series_cnt_i(series_cnt),
		.state_rd_addr_o(state_rd_addr), .coef_rd_addr_o(coef_rd_addr)
	);

	// State RAM is written only by the datapath
	dp_ram #(.word_t(state_word_t)) u_state_ram (
		.clk_i(clk_i), .wr_en_i(state_wr_o.we), .wr_addr_i(state_wr_o.addr),
		.wr_data_i(state_wr_o.word), .rd_addr_i(state_rd_addr), .rd_data_o(state_rd)
	);

	dp_ram #(.word_t(coef_word_t)) u_coef_ram (
		.clk_i(clk_i), .wr_en_i(coef_wr_i.we), .wr_addr_i(coef_wr_i.addr),
		.wr_data_i(coef_wr_i.word), .rd_addr_i(coef_rd_addr), .rd_data_o(coef_rd)
	);

	resonator_datapath u_dp (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst),
		.load_sample_i(load_sample), .load_sum_i(load_sum), .calc_i(calc),
		.wr_harm_i(wr_harm), .wr_sum_i(wr_sum), .state_rd_i(state_rd),
		.coef_rd_i(coef_rd), .state_rd_addr_i(state_rd_addr), .state_wr_o(state_wr_o)
	);

endmodule

// File: testbench/resonant_model.svh
int model_co[HARMONICS_NUM];
int model_si[HARMONICS_NUM];
int model_sample[IN_SERIES_NUM];
int model_x1[IN_SERIES_NUM][HARMONICS_NUM];    // States start at zero like the state RAM
int model_x2[IN_SERIES_NUM][HARMONICS_NUM];
int model_sum[IN_SERIES_NUM];
mem_wr_t exp_q[$];    // State writes still due on the write port

function automatic int wrap_sample(input longint v);
	return int'($signed(v[SAMPLE_W-1:0]));    // Keep 18 bits and sign extend
endfunction

function automatic void push_write(input int s, input int offset, input int x1, input int x2);
	mem_wr_t w;
	w.we = 1'b1;
	w.addr = {SERIES_CNT_W'(s), BANK_W'(offset)};    // Series bank above the in-bank offset
	w.word.x1 = SAMPLE_W'(x1);
	w.word.x2 = SAMPLE_W'(x2);
	exp_q.push_back(w);
endfunction

function automatic void predict_run();
	int s;
	int h;
	int err;
	int acc;
	longint p1;
	longint p2;
	for (s = 0; s < IN_SERIES_NUM; s++) begin
		err = wrap_sample(longint'(model_sample[s]) - longint'(model_sum[s]));
		acc = 0;
		for (h = 0; h < HARMONICS_NUM; h++) begin
			p1 = longint'(model_co[h]) * longint'(model_x1[s][h])
				- longint'(model_si[h]) * longint'(model_x2[s][h]);
			p2 = longint'(model_si[h]) * longint'(model_x1[s][h])
				+ longint'(model_co[h]) * longint'(model_x2[s][h]);
			model_x1[s][h] = wrap_sample(longint'(wrap_sample(p1 >>> Q_SHIFT))
				+ longint'(err));
			model_x2[s][h] = wrap_sample(p2 >>> Q_SHIFT);
			acc = wrap_sample(longint'(acc) + longint'(model_x1[s][h]));
			push_write(s, h, model_x1[s][h], model_x2[s][h]);
		end
		model_sum[s] = acc;
		push_write(s, STATE_SUM_OFFSET, acc, 0);    // Sum slot keeps x2 at zero
	end
endfunction

// File: testbench/resonant_tb.sv
module resonant_tb
	import resonant_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WRITES_PER_RUN = IN_SERIES_NUM * (HARMONICS_NUM + 1);

	logic clk_i;
	logic harmonics_rst;
	logic start_i;
	coef_wr_t coef_wr_i;
	logic busy_o;
	mem_wr_t state_wr_o;
	logic [31:0] lfsr_q;
	int wr_count;
	string test_name;

	`include "resonant_model.svh"

	resonant_top u_dut (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst), .start_i(start_i),
		.coef_wr_i(coef_wr_i), .busy_o(busy_o), .state_wr_o(state_wr_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	// ========================================
	// Stimulus and checking helpers
	// ========================================
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);    // Taps 32, 22, 2, 1
	endfunction

	task automatic draw_signed(input int bits, output int value);
		logic [31:0] raw;
		int i;
		raw = '0;
		for (i = 0; i < bits; i++) begin
			raw = {raw[30:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
		value = $signed(raw << (32 - bits)) >>> (32 - bits);
	endtask

	task automatic check_eq(input string what, input longint expected, input longint actual);
		assert (expected == actual) else begin
			$display("Error: %s, %s expected %0d actual %0d", test_name, what, expected, actual);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic wait_busy(input logic level, input int limit, input string what);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk_i);
			cycles++;
			assert (cycles <= limit) else begin
				$display("Timeout in %s: %s within %0d cycles", test_name, what, limit);
				$display("TEST FAILED");
				$fatal(1);
			end
		end while (busy_o != level);
	endtask

	task automatic write_coef(input int addr, input int co, input int si);
		coef_wr_t w;
		w.we = 1'b1;
		w.addr = ADDR_W'(addr);
		w.word.co = SAMPLE_W'(co);
		w.word.si = SAMPLE_W'(si);
		@(posedge clk_i);
		coef_wr_i <= w;
	endtask

	task automatic load_coefs();
		int h;
		for (h = 0; h < HARMONICS_NUM; h++) begin
			draw_signed(16, model_co[h]);    // Magnitude at most 0.5
			draw_signed(16, model_si[h]);
			write_coef(h, model_co[h], model_si[h]);
		end
		@(posedge clk_i);
		coef_wr_i <= '0;
	endtask

	task automatic load_samples();
		int s;
		int junk;
		for (s = 0; s < IN_SERIES_NUM; s++) begin
			draw_signed(13, model_sample[s]);
			draw_signed(16, junk);    // si of a sample word is unused
			write_coef(COEF_COMMON_BASE + s, model_sample[s], junk);
		end
		@(posedge clk_i);
		coef_wr_i <= '0;
	endtask

	task automatic run_and_check(input bit extra_start);
		predict_run();
		wr_count = 0;
		@(posedge clk_i);
		start_i <= 1'b1;
		@(posedge clk_i);
		start_i <= 1'b0;
		wait_busy(1'b1, 10, "busy_o did not rise after start_i");
		if (extra_start) begin
			repeat (20) @(negedge clk_i);
			check_eq("busy_o before second start", 64'd1, longint'(busy_o));
			@(posedge clk_i);
			start_i <= 1'b1;
			@(posedge clk_i);
			start_i <= 1'b0;
		end
		wait_busy(1'b0, 1000, "busy_o did not fall");
		check_eq("write count", longint'(WRITES_PER_RUN), longint'(wr_count));
	endtask

	// Compare every state write against the model in order
	always @(negedge clk_i) begin : write_monitor
		mem_wr_t exp_w;
		if (!harmonics_rst && state_wr_o.we) begin
			wr_count++;
			assert (exp_q.size() != 0) else begin
				$display("Unexpected state write to address %0d in %s", state_wr_o.addr, test_name);
				$display("TEST FAILED");
				$fatal(1);
			end
			exp_w = exp_q.pop_front();
			check_eq("write address", longint'(exp_w.addr), longint'(state_wr_o.addr));
			check_eq("x1", longint'(exp_w.word.x1), longint'(state_wr_o.word.x1));
			check_eq("x2", longint'(exp_w.word.x2), longint'(state_wr_o.word.x2));
		end
	end

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		harmonics_rst = 1'b1;
		start_i = 1'b0;
		coef_wr_i = '0;
		lfsr_q = 32'd96;
		wr_count = 0;
		test_name = "reset idle";
		repeat (3) @(posedge clk_i);
		harmonics_rst <= 1'b0;
		repeat (5) begin
			@(negedge clk_i);
			check_eq("busy_o", 64'd0, longint'(busy_o));
			check_eq("state_wr_o.we", 64'd0, longint'(state_wr_o.we));
		end
		test_name = "first run";
		load_coefs();
		load_samples();
		run_and_check(1'b0);
		test_name = "second run";    // Errors now use the stored sums
		load_samples();
		run_and_check(1'b0);
		test_name = "start while busy";
		load_samples();
		run_and_check(1'b1);
		repeat (10) @(negedge clk_i);
		check_eq("busy_o after run", 64'd0, longint'(busy_o));
		$display("TEST OK");
		$finish;
	end

endmodule

// File: sources.f
+incdir+testbench
hw/resonant_pkg.sv
hw/dp_ram.sv
hw/addr_gen.sv
hw/loop_counters.sv
hw/resonant_sequencer.sv
hw/resonator_datapath.sv
hw/resonant_top.sv
testbench/resonant_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the resonator bank testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module resonant_tb -f sources.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/Vresonant_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi
exit 0
